/* filelist.f */
verilog/capture_pkg.sv
verilog/us_timebase.sv
verilog/pulse_gen.sv
verilog/adc_capture.sv
verilog/pulse_capture_top.sv
sim/tb_pulse_capture.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it, search the output for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_pulse_capture -f filelist.f -o tb_sim \
    && out=$(./obj_dir/tb_sim) \
    && echo "$out" \
    && echo "$out" | grep -qx "all tests passed" \
    && echo "simulation PASS" && exit 0 \
    || { echo "$out"; echo "simulation FAIL"; exit 1; }

/* sim/tb_pulse_capture.sv */
`timescale 1ns/1ns

module tb_pulse_capture
    import capture_pkg::*;
();

    localparam int CLKS      = 8;               // clocks per us in this bench
    localparam int ADDR_W    = 6;
    localparam int DEPTH     = 1 << ADDR_W;     // 64 bram words
    localparam int NUM_TESTS = 6;
    localparam int HORIZON   = 512;             // expectation window per test
    localparam int HIST_LEN  = 4096;
    localparam logic [31:0] LFSR_MASK = 32'h8020_0003;

    // ------------------------------------------------------------------------
    // DUT signals
    // ------------------------------------------------------------------------
    logic              clk_200m;
    logic              i_arst_n;
    logic              i_start;
    pulse_cnt_t        i_pulse_width;
    pulse_cnt_t        i_pulse_num;
    gap_us_t           i_gap_us;
    capt_us_t          i_capture_us;
    adc_sample_t       i_adc_data;
    logic              i_adc_or;
    logic              o_pulse;
    logic              o_trig;
    logic              o_pulse_done;
    logic [ADDR_W-1:0] o_bram_addr;
    bram_word_t        o_bram_data;
    logic              o_bram_we;
    logic              o_capture_done;

    // test table: name, width, num, gap_us, capture_us
    string tname  [NUM_TESTS] = '{"single", "multi_short", "num_zero", "width_zero",
                                  "deep", "capt_zero"};
    int    twidth [NUM_TESTS] = '{3, 2, 4, 0, 5, 1};
    int    tnum   [NUM_TESTS] = '{1, 3, 0, 2, 2, 1};
    int    tgap   [NUM_TESTS] = '{2, 3, 1, 1, 2, 1};
    int    tcapt  [NUM_TESTS] = '{2, 1, 2, 1, 10, 0};

    // reference model state, indexed by cycle offset from start
    bit    exp_pulse [HORIZON];
    bit    exp_trig  [HORIZON];
    bit    exp_pdone [HORIZON];
    bit    exp_we    [HORIZON];
    bit    exp_cdone [HORIZON];
    int    exp_addr  [HORIZON];
    int    exp_src   [HORIZON];             // offset of the sample to be written
    logic [12:0] hist [HIST_LEN];           // {or, sample} driven per cycle

    logic [31:0] lfsr;
    int    cycle;
    int    limit;
    int    errors;
    int    t_start;                         // start cycle of current row, -1 before any
    int    pdone_seen;
    int    capt_seen;
    int    n_capt;
    string cur_name;

    pulse_capture_top #(
        .CLKS_PER_US    (CLKS),
        .BRAM_ADDR_W    (ADDR_W)
    ) uut (
        .clk_200m       (clk_200m),
        .i_arst_n       (i_arst_n),
        .i_start        (i_start),
        .i_pulse_width  (i_pulse_width),
        .i_pulse_num    (i_pulse_num),
        .i_gap_us       (i_gap_us),
        .i_capture_us   (i_capture_us),
        .i_adc_data     (i_adc_data),
        .i_adc_or       (i_adc_or),
        .o_pulse        (o_pulse),
        .o_trig         (o_trig),
        .o_pulse_done   (o_pulse_done),
        .o_bram_addr    (o_bram_addr),
        .o_bram_data    (o_bram_data),
        .o_bram_we      (o_bram_we),
        .o_capture_done (o_capture_done)
    );

    always #4 clk_200m = ~clk_200m;         // 8 ns period

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_MASK) : (lfsr >> 1);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic int write_count(input int cap);
        int n;
        n = cap * CLKS;
        return (n > DEPTH) ? DEPTH : n;     // depth limit
    endfunction

    function automatic int period(input int w, input int gap);
        int wid;
        int g;
        wid = (w == 0) ? 1 : w;             // zero width acts as one
        g   = (gap == 0) ? 1 : gap;
        return wid + g * CLKS;
    endfunction

    // ------------------------------------------------------------------------
    // reference model, fills the expectation window for one row
    // ------------------------------------------------------------------------
    task automatic build_expect(input int w, input int num, input int gap, input int cap,
                                output int captures);
        int wid;
        int p;
        int n;
        int rise;
        int ready;
        for (int i = 0; i < HORIZON; i++) begin
            exp_pulse[i] = 0;
            exp_trig[i]  = 0;
            exp_pdone[i] = 0;
            exp_we[i]    = 0;
            exp_cdone[i] = 0;
            exp_addr[i]  = 0;
            exp_src[i]   = 0;
        end
        wid      = (w == 0) ? 1 : w;
        p        = period(w, gap);
        n        = write_count(cap);
        captures = 0;
        ready    = 0;                       // capture idle from this offset on
        if (num == 0) begin
            exp_pdone[1] = 1;               // empty train
        end else begin
            for (int k = 0; k < num; k++) begin
                rise = 1 + k * p;
                exp_trig[rise] = 1;
                for (int j = 0; j < wid; j++)
                    exp_pulse[rise + j] = 1;
                if (rise >= ready) begin    // trigger taken, else absorbed
                    for (int j = 0; j < n; j++) begin
                        exp_we[rise + 1 + j]   = 1;
                        exp_addr[rise + 1 + j] = j;
                        exp_src[rise + 1 + j]  = rise + j;
                    end
                    exp_cdone[rise + 1 + n] = 1;
                    ready    = rise + 1 + n;
                    captures = captures + 1;
                end
            end
            exp_pdone[1 + num * p] = 1;
        end
    endtask

    task automatic check_val(input string what, input logic [31:0] exp_v,
                             input logic [31:0] got_v);
        assert (got_v === exp_v) else begin
            errors = errors + 1;
            $display("ERR %s %s at cycle %0d: expected %0h, actual %0h",
                     cur_name, what, cycle, exp_v, got_v);
        end
    endtask

    // ------------------------------------------------------------------------
    // cycle count, watchdog, adc stimulus
    // ------------------------------------------------------------------------
    always @(posedge clk_200m) begin
        cycle = cycle + 1;
        if (limit > 0 && cycle > limit) begin
            $display("timeout: no finish within %0d cycles", limit);
            $display("errors: %0d", errors);
            $display("tests failed");
            $finish;
        end
    end

    always @(posedge clk_200m) begin
        #1;
        i_adc_data = adc_sample_t'(rand_bits(ADC_W));   // new sample every clock
        i_adc_or   = 1'(rand_bits(1));
        hist[cycle % HIST_LEN] = {i_adc_or, i_adc_data};
    end

    // outputs sampled mid-cycle, away from both edges
    always @(negedge clk_200m) begin
        int   off;
        bit   in_win;
        logic [31:0] exp_data;
        off    = cycle - t_start;
        in_win = (t_start >= 0) && (off >= 0) && (off < HORIZON);
        if (cycle >= 1) begin
            check_val("o_pulse", in_win ? exp_pulse[off] : 0, o_pulse);
            check_val("o_trig", in_win ? exp_trig[off] : 0, o_trig);
            check_val("o_pulse_done", in_win ? exp_pdone[off] : 0, o_pulse_done);
            check_val("o_bram_we", in_win ? exp_we[off] : 0, o_bram_we);
            check_val("o_capture_done", in_win ? exp_cdone[off] : 0, o_capture_done);
            if (in_win && exp_we[off]) begin
                exp_data = {19'b0, hist[(t_start + exp_src[off]) % HIST_LEN]};
                check_val("o_bram_addr", exp_addr[off], o_bram_addr);
                check_val("o_bram_data", exp_data, o_bram_data);
            end else if (t_start < 0) begin
                check_val("o_bram_addr", 0, o_bram_addr);   // idle after reset
            end
            if (o_pulse_done)
                pdone_seen = pdone_seen + 1;
            if (o_capture_done)
                capt_seen = capt_seen + 1;
        end
    end

    // ------------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------------
    initial begin
        clk_200m      = 1'b0;
        i_arst_n      = 1'b0;
        i_start       = 1'b0;
        i_pulse_width = '0;
        i_pulse_num   = '0;
        i_gap_us      = '0;
        i_capture_us  = '0;
        i_adc_data    = '0;
        i_adc_or      = 1'b0;
        lfsr          = 32'hb77faf22;
        cycle         = 0;
        errors        = 0;
        t_start       = -1;
        pdone_seen    = 0;
        capt_seen     = 0;
        cur_name      = "reset";
        limit         = 0;
        for (int t = 0; t < NUM_TESTS; t++)
            limit = limit + tnum[t] * period(twidth[t], tgap[t]) + write_count(tcapt[t]) + 50;

        repeat (5) @(posedge clk_200m);
        #1 i_arst_n = 1'b1;
        repeat (4) @(posedge clk_200m);     // idle outputs checked here

        for (int t = 0; t < NUM_TESTS; t++) begin
            @(posedge clk_200m);
            #1;
            build_expect(twidth[t], tnum[t], tgap[t], tcapt[t], n_capt);
            cur_name      = tname[t];
            i_pulse_width = pulse_cnt_t'(twidth[t]);
            i_pulse_num   = pulse_cnt_t'(tnum[t]);
            i_gap_us      = gap_us_t'(tgap[t]);
            i_capture_us  = capt_us_t'(tcapt[t]);
            i_start       = 1'b1;
            t_start       = cycle;
            pdone_seen    = 0;
            capt_seen     = 0;
            @(posedge clk_200m);
            #1 i_start = 1'b0;
            while (pdone_seen == 0 || capt_seen < n_capt)
                @(posedge clk_200m);
            repeat (3) @(posedge clk_200m); // no stray strobes after the row
            #1;
            check_val("train done count", 1, pdone_seen);
            check_val("capture count", n_capt, capt_seen);
        end

        $display("errors: %0d", errors);
        if (errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

/* verilog/adc_capture.sv */
`timescale 1ns/1ns

module adc_capture
    import capture_pkg::*;
#(
    parameter int CLKS_PER_US = 200,
    parameter int BRAM_ADDR_W = 11
) (
    input  logic                   clk_200m,
    input  logic                   i_arst_n,
    input  logic                   i_trig,          // starts a capture when idle
    input  capt_us_t               i_capture_us,    // capture length in us
    input  adc_sample_t            i_adc_data,
    input  logic                   i_adc_or,        // adc over-range
    output logic [BRAM_ADDR_W-1:0] o_bram_addr,
    output bram_word_t             o_bram_data,
    output logic                   o_bram_we,
    output logic                   o_capture_done
);

    localparam logic [BRAM_ADDR_W-1:0] ADDR_LAST = '1;  // top bram word

    capt_state_t state;
    capt_us_t    len_q;                         // latched capture length
    capt_us_t    us_cnt;                        // us elapsed in capture
    adc_sample_t adc_q;                         // sample one cycle back
    logic        or_q;

    logic run;
    logic us_tick;
    logic len_end;
    logic depth_end;

    assign run       = (state == CP_RUN);
    assign len_end   = us_tick && (us_cnt == len_q - capt_us_t'(1));
    assign depth_end = (o_bram_addr == ADDR_LAST);   // bram full after this write
    assign o_bram_we = run;                          // one write per run cycle

    us_timebase #(
        .CLKS_PER_US (CLKS_PER_US)
    ) u_capt_timebase (
        .clk_200m    (clk_200m),
        .i_arst_n    (i_arst_n),
        .i_run       (run),
        .o_us_tick   (us_tick)
    );

    // ------------------------------------------------------------------------
    // input sample register, feeds bram data
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_200m or negedge i_arst_n) begin
        if (!i_arst_n) begin
            adc_q <= '0;
            or_q  <= 1'b0;
        end else begin
            adc_q <= i_adc_data;                // sampled every clock
            or_q  <= i_adc_or;
        end
    end

    // pack sample and over-range flag, upper bits zero
    always_comb begin
        o_bram_data             = '0;
        o_bram_data[ADC_W-1:0]  = adc_q;
        o_bram_data[ADC_OR_BIT] = or_q;
    end

    // ------------------------------------------------------------------------
    // capture fsm
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_200m or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state          <= CP_IDLE;
            len_q          <= '0;
            us_cnt         <= '0;
            o_bram_addr    <= '0;
            o_capture_done <= 1'b0;
        end else begin
            o_capture_done <= 1'b0;
            case (state)
                CP_IDLE: begin
                    if (i_trig) begin
                        if (i_capture_us == '0) begin
                            o_capture_done <= 1'b1;   // zero length, no writes
                        end else begin
                            len_q       <= i_capture_us;
                            us_cnt      <= '0;
                            o_bram_addr <= '0;        // every capture from word 0
                            state       <= CP_RUN;
                        end
                    end
                end

                CP_RUN: begin
                    // triggers are ignored here
                    if (len_end || depth_end) begin
                        o_capture_done <= 1'b1;       // last write this cycle
                        state          <= CP_IDLE;
                    end else begin
                        o_bram_addr <= o_bram_addr + 1'b1;
                        if (us_tick) begin
                            us_cnt <= us_cnt + capt_us_t'(1);
                        end
                    end
                end

                default: begin
                    state <= CP_IDLE;
                end
            endcase
        end
    end

endmodule

/* verilog/capture_pkg.sv */
package capture_pkg;

    // ------------------------------------------------------------------------
    // field widths
    // ------------------------------------------------------------------------
    localparam int PULSE_W     = 11;            // pulse width / pulse count word
    localparam int GAP_W       = 16;            // gap length in us
    localparam int CAPT_W      = 10;            // capture length in us
    localparam int ADC_W       = 12;            // AD9434 sample bits
    localparam int BRAM_DATA_W = 32;            // BRAM word

    // over-range flag sits just above the sample in a BRAM word
    localparam int ADC_OR_BIT  = ADC_W;         // bit 12

    // ------------------------------------------------------------------------
    // data types
    // ------------------------------------------------------------------------
    typedef logic [PULSE_W-1:0]     pulse_cnt_t;    // width, num, counters
    typedef logic [GAP_W-1:0]       gap_us_t;       // gap setting / gap counter
    typedef logic [CAPT_W-1:0]      capt_us_t;      // capture setting / us counter
    typedef logic [ADC_W-1:0]       adc_sample_t;   // raw adc code
    typedef logic [BRAM_DATA_W-1:0] bram_word_t;    // {zeros, or, sample}

    // ------------------------------------------------------------------------
    // state machines
    // ------------------------------------------------------------------------
    typedef enum logic [1:0] {
        PG_IDLE = 2'd0,                         // waiting for start
        PG_HIGH = 2'd1,                         // output pulse high
        PG_GAP  = 2'd2                          // low time between pulses
    } pulse_state_t;

    typedef enum logic {
        CP_IDLE = 1'b0,                         // waiting for trigger
        CP_RUN  = 1'b1                          // writing samples to bram
    } capt_state_t;

endpackage

/* verilog/pulse_capture_top.sv */
`timescale 1ns/1ns

module pulse_capture_top
    import capture_pkg::*;
#(
    parameter int CLKS_PER_US = 200,            // clk_200m cycles per us
    parameter int BRAM_ADDR_W = 11              // 2048 word capture buffer
) (
    input  logic                   clk_200m,
    input  logic                   i_arst_n,

    // pulse generator settings
    input  logic                   i_start,
    input  pulse_cnt_t             i_pulse_width,
    input  pulse_cnt_t             i_pulse_num,
    input  gap_us_t                i_gap_us,

    // capture settings and adc sample
    input  capt_us_t               i_capture_us,
    input  adc_sample_t            i_adc_data,
    input  logic                   i_adc_or,

    // pulse outputs
    output logic                   o_pulse,
    output logic                   o_trig,
    output logic                   o_pulse_done,

    // bram write port
    output logic [BRAM_ADDR_W-1:0] o_bram_addr,
    output bram_word_t             o_bram_data,
    output logic                   o_bram_we,
    output logic                   o_capture_done
);

    // ------------------------------------------------------------------------
    // pulse generator
    // ------------------------------------------------------------------------
    pulse_gen #(
        .CLKS_PER_US    (CLKS_PER_US)
    ) u_pulse_gen (
        .clk_200m       (clk_200m),
        .i_arst_n       (i_arst_n),
        .i_start        (i_start),
        .i_pulse_width  (i_pulse_width),
        .i_pulse_num    (i_pulse_num),
        .i_gap_us       (i_gap_us),
        .o_pulse        (o_pulse),
        .o_trig         (o_trig),       // also fires the capture
        .o_done         (o_pulse_done)
    );

    // ------------------------------------------------------------------------
    // AD9434 capture into bram
    // ------------------------------------------------------------------------
    adc_capture #(
        .CLKS_PER_US    (CLKS_PER_US),
        .BRAM_ADDR_W    (BRAM_ADDR_W)
    ) u_adc_capture (
        .clk_200m       (clk_200m),
        .i_arst_n       (i_arst_n),
        .i_trig         (o_trig),       // every pulse rise, busy captures skip it
        .i_capture_us   (i_capture_us),
        .i_adc_data     (i_adc_data),
        .i_adc_or       (i_adc_or),
        .o_bram_addr    (o_bram_addr),
        .o_bram_data    (o_bram_data),
        .o_bram_we      (o_bram_we),
        .o_capture_done (o_capture_done)
    );

endmodule

/* verilog/pulse_gen.sv */
`timescale 1ns/1ns

module pulse_gen
    import capture_pkg::*;
#(
    parameter int CLKS_PER_US = 200
) (
    input  logic       clk_200m,
    input  logic       i_arst_n,
    input  logic       i_start,                 // one-cycle start strobe
    input  pulse_cnt_t i_pulse_width,           // high time in clocks
    input  pulse_cnt_t i_pulse_num,             // pulses per train
    input  gap_us_t    i_gap_us,                // low time in us
    output logic       o_pulse,
    output logic       o_trig,                  // first high cycle of a pulse
    output logic       o_done                   // train finished
);

    // ------------------------------------------------------------------------
    // registers
    // ------------------------------------------------------------------------
    pulse_state_t state;
    pulse_cnt_t   width_q;                      // latched width, never 0
    gap_us_t      gap_q;                        // latched gap, never 0
    pulse_cnt_t   pulses_left;                  // incl. the one in flight
    pulse_cnt_t   high_cnt;                     // high cycles shown so far
    gap_us_t      gap_cnt;                      // us elapsed in gap

    logic gap_run;
    logic us_tick;
    logic high_end;
    logic gap_end;
    logic last_pulse;

    assign gap_run    = (state == PG_GAP);      // timebase only runs in gap
    assign high_end   = (high_cnt == width_q);
    assign gap_end    = us_tick && (gap_cnt == gap_q - gap_us_t'(1));
    assign last_pulse = (pulses_left == pulse_cnt_t'(1));

    us_timebase #(
        .CLKS_PER_US (CLKS_PER_US)
    ) u_gap_timebase (
        .clk_200m    (clk_200m),
        .i_arst_n    (i_arst_n),
        .i_run       (gap_run),
        .o_us_tick   (us_tick)
    );

    // ------------------------------------------------------------------------
    // pulse train fsm
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_200m or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state       <= PG_IDLE;
            width_q     <= pulse_cnt_t'(1);
            gap_q       <= gap_us_t'(1);
            pulses_left <= '0;
            high_cnt    <= '0;
            gap_cnt     <= '0;
            o_pulse     <= 1'b0;
            o_trig      <= 1'b0;
            o_done      <= 1'b0;
        end else begin
            o_trig <= 1'b0;                     // strobes default low
            o_done <= 1'b0;
            case (state)
                PG_IDLE: begin
                    if (i_start) begin
                        // zero settings count as one unit
                        width_q <= (i_pulse_width == '0) ? pulse_cnt_t'(1) : i_pulse_width;
                        gap_q   <= (i_gap_us == '0) ? gap_us_t'(1) : i_gap_us;
                        if (i_pulse_num == '0) begin
                            o_done <= 1'b1;     // empty train, done right away
                        end else begin
                            pulses_left <= i_pulse_num;
                            high_cnt    <= pulse_cnt_t'(1);
                            o_pulse     <= 1'b1; // first rise next cycle
                            o_trig      <= 1'b1;
                            state       <= PG_HIGH;
                        end
                    end
                end

                PG_HIGH: begin
                    if (high_end) begin
                        o_pulse <= 1'b0;        // width reached
                        gap_cnt <= '0;
                        state   <= PG_GAP;
                    end else begin
                        high_cnt <= high_cnt + pulse_cnt_t'(1);
                    end
                end

                PG_GAP: begin
                    if (gap_end) begin
                        if (last_pulse) begin
                            o_done <= 1'b1;     // last low phase over
                            state  <= PG_IDLE;
                        end else begin
                            pulses_left <= pulses_left - pulse_cnt_t'(1);
                            high_cnt    <= pulse_cnt_t'(1);
                            o_pulse     <= 1'b1; // next rise, P after the last
                            o_trig      <= 1'b1;
                            state       <= PG_HIGH;
                        end
                    end else if (us_tick) begin
                        gap_cnt <= gap_cnt + gap_us_t'(1);
                    end
                end

                default: begin
                    o_pulse <= 1'b0;
                    state   <= PG_IDLE;
                end
            endcase
        end
    end

endmodule

/* verilog/us_timebase.sv */
`timescale 1ns/1ns

// microsecond strobe, phase restarts every time i_run rises
module us_timebase #(
    parameter int CLKS_PER_US = 200
) (
    input  logic clk_200m,
    input  logic i_arst_n,
    input  logic i_run,
    output logic o_us_tick
);

    localparam int CNT_W = (CLKS_PER_US > 1) ? $clog2(CLKS_PER_US) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLKS_PER_US - 1);

    logic [CNT_W-1:0] cnt;                      // clocks into current us
    logic             wrap;                     // last clock of the us

    assign wrap      = (cnt == CNT_LAST);
    assign o_us_tick = i_run && wrap;           // one cycle per us while running

    always_ff @(posedge clk_200m or negedge i_arst_n) begin
        if (!i_arst_n) begin
            cnt <= '0;
        end else if (!i_run) begin
            cnt <= '0;                          // idle, hold phase at zero
        end else if (wrap) begin
            cnt <= '0;                          // start next us
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

endmodule
